// File: source/mul_arith_pkg.sv
package mul_arith_pkg;

    ////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN   = 32;
    localparam int PROD_W = 2 * XLEN;

    // one row per multiplier bit
    localparam int NUM_PP = XLEN;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [PROD_W-1:0] product_t;

    ////////////////////////////////////////////////////////////
    // compressor tree sizing
    ////////////////////////////////////////////////////////////

    // 32 -> 16 -> 8 -> 4 -> 2
    localparam int TREE_LEVELS = $clog2(NUM_PP) - 1;

    // all levels packed back to back, pp rows first, final pair last
    localparam int TREE_ROWS = 2 * NUM_PP - 2;

endpackage

// File: source/mul_op_pkg.sv
package mul_op_pkg;

    ////////////////////////////////////////////////////////////
    // M extension multiply group
    ////////////////////////////////////////////////////////////

    localparam int FUNC3_W = 3;

    typedef logic [FUNC3_W-1:0] func3_t;

    // low half, signed x signed
    localparam func3_t MUL_F3    = 3'd0;

    // high half, signed x signed
    localparam func3_t MULH_F3   = 3'd1;

    // high half, signed x unsigned
    localparam func3_t MULHSU_F3 = 3'd2;

    // high half, unsigned x unsigned
    localparam func3_t MULHU_F3  = 3'd3;

endpackage

// File: source/mul_operand_if.sv
`timescale 1ns/1ps

interface mul_operand_if;

    import mul_arith_pkg::*;
    import mul_op_pkg::*;

    // registered operands
    word_t    op_a;
    word_t    op_b;
    func3_t   func3;

    // last tree level, still redundant form
    product_t sum_row;
    product_t carry_row;

    modport ctrl_mp (
        output op_a,
        output op_b,
        output func3,
        input  sum_row,
        input  carry_row
    );

    modport tree_mp (
        input  op_a,
        input  op_b,
        input  func3
    );

endinterface

// File: source/mul_pp_gen.sv
`timescale 1ns/1ps

module mul_pp_gen (
    mul_operand_if.tree_mp                          bus,
    output mul_arith_pkg::product_t [mul_arith_pkg::NUM_PP-1:0] rows_o
);

    import mul_arith_pkg::*;
    import mul_op_pkg::*;

    logic  signed_a;
    logic  signed_b;
    logic  a_sign;
    word_t neg_a;
    word_t top_mult;

    ////////////////////////////////////////////////////////////
    // operand signedness
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (bus.func3)
            MUL_F3, MULH_F3: begin
                signed_a = 1'b1;
                signed_b = 1'b1;
            end
            MULHSU_F3: begin
                signed_a = 1'b1;
                signed_b = 1'b0;
            end
            MULHU_F3: begin
                signed_a = 1'b0;
                signed_b = 1'b0;
            end
            // reserved codes behave as MUL
            default: begin
                signed_a = 1'b1;
                signed_b = 1'b1;
            end
        endcase
    end

    assign a_sign = signed_a & bus.op_a[XLEN-1];
    assign neg_a  = ~bus.op_a + 1'b1;

    ////////////////////////////////////////////////////////////
    // partial products
    ////////////////////////////////////////////////////////////

    always_comb begin
        // gated multiplicand, sign extended, placed at column i
        for (int i = 0; i < NUM_PP - 1; i++) begin
            rows_o[i] = ({{XLEN{a_sign}}, bus.op_a} & {PROD_W{bus.op_b[i]}}) << i;
        end

        // top row weighs -2^31 when op_b is signed
        top_mult = (signed_b ? neg_a : bus.op_a) & {XLEN{bus.op_b[XLEN-1]}};

        rows_o[NUM_PP-1] = '0;
        rows_o[NUM_PP-1][PROD_W-2 -: XLEN] = top_mult;

        // bit 63 of the negated or sign extended multiplicand
        rows_o[NUM_PP-1][PROD_W-1] = (a_sign ^ (signed_b & bus.op_b[XLEN-1]))
                                     & bus.op_b[XLEN-1] & top_mult[XLEN-1];
    end

endmodule

// File: source/mul_compress_stage.sv
`timescale 1ns/1ps

module mul_compress_stage #(
    parameter int ROWS = 32
) (
    input  mul_arith_pkg::product_t [ROWS-1:0]   rows_i,
    output mul_arith_pkg::product_t [ROWS/2-1:0] rows_o
);

    import mul_arith_pkg::*;

    localparam int GROUPS = ROWS / 4;

    // returns {carry, sum}
    function automatic logic [1:0] full_add(
        input logic a,
        input logic b,
        input logic c
    );
        full_add = {(a & b) | (a & c) | (b & c), a ^ b ^ c};
    endfunction

    ////////////////////////////////////////////////////////////
    // one 4:2 compressor chain per group of four rows
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < GROUPS; g++) begin : g_group
        product_t in1;
        product_t in2;
        product_t in3;
        product_t in4;
        product_t mid;
        product_t cout;
        product_t sum_row;
        product_t carry_hi;

        assign in1 = rows_i[4*g];
        assign in2 = rows_i[4*g+1];
        assign in3 = rows_i[4*g+2];
        assign in4 = rows_i[4*g+3];

        for (genvar j = 0; j < PROD_W; j++) begin : g_col
            logic cin;

            // lateral chain from the column below
            if (j == 0) begin : g_first
                assign cin = 1'b0;
            end else begin : g_next
                assign cin = cout[j-1];
            end

            assign {cout[j], mid[j]}         = full_add(in1[j], in2[j], in3[j]);
            assign {carry_hi[j], sum_row[j]} = full_add(mid[j], in4[j], cin);
        end

        // carries out of bit 63 fall off, result stays exact mod 2^64
        assign rows_o[2*g]   = sum_row;
        assign rows_o[2*g+1] = {carry_hi[PROD_W-2:0], 1'b0};
    end

endmodule

// File: source/mul_req_ack_ctrl.sv
`timescale 1ns/1ps

module mul_req_ack_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 req_i,
    input  mul_arith_pkg::word_t op_a_i,
    input  mul_arith_pkg::word_t op_b_i,
    input  mul_op_pkg::func3_t   func3_i,
    output logic                 ack_o,
    output mul_arith_pkg::word_t result_o,
    mul_operand_if.ctrl_mp       bus
);

    import mul_arith_pkg::*;
    import mul_op_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } state_t;

    state_t   state;
    product_t product;
    word_t    result_sel;

    ////////////////////////////////////////////////////////////
    // final add and half select
    ////////////////////////////////////////////////////////////

    assign product = bus.sum_row + bus.carry_row;

    always_comb begin
        case (bus.func3)
            MULH_F3, MULHSU_F3, MULHU_F3: result_sel = product[PROD_W-1:XLEN];
            default:                      result_sel = product[XLEN-1:0];
        endcase
    end

    ////////////////////////////////////////////////////////////
    // four-phase handshake
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state    <= IDLE;
            ack_o    <= 1'b0;
            result_o <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_i) begin
                        state <= BUSY;
                    end
                end
                // tree settled during this cycle
                BUSY: begin
                    state    <= DONE;
                    ack_o    <= 1'b1;
                    result_o <= result_sel;
                end
                // hold until the requester lets go
                DONE: begin
                    if (!req_i) begin
                        state <= IDLE;
                        ack_o <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // operand capture on request
    always_ff @(posedge clk_i) begin
        if (state == IDLE && req_i) begin
            bus.op_a  <= op_a_i;
            bus.op_b  <= op_b_i;
            bus.func3 <= func3_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // protocol checks
    ////////////////////////////////////////////////////////////

    ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ack_o) |-> $past(req_i));

    result_held: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_o && $past(ack_o) |-> $stable(result_o));

    ack_low_after_reset: assert property (@(posedge clk_i)
        rst_i |=> !ack_o);

endmodule

// File: source/mul_top.sv
`timescale 1ns/1ps

module mul_top (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 req_i,
    input  mul_arith_pkg::word_t op_a_i,
    input  mul_arith_pkg::word_t op_b_i,
    input  mul_op_pkg::func3_t   func3_i,
    output logic                 ack_o,
    output mul_arith_pkg::word_t result_o
);

    import mul_arith_pkg::*;

    // every tree level, rows of level k start where level k-1 ended
    product_t [TREE_ROWS-1:0] tree_rows;

    mul_operand_if bus ();

    mul_req_ack_ctrl u_ctrl (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (req_i),
        .op_a_i   (op_a_i),
        .op_b_i   (op_b_i),
        .func3_i  (func3_i),
        .ack_o    (ack_o),
        .result_o (result_o),
        .bus      (bus)
    );

    mul_pp_gen u_pp_gen (
        .bus    (bus),
        .rows_o (tree_rows[NUM_PP-1:0])
    );

    ////////////////////////////////////////////////////////////
    // 4:2 tree levels
    ////////////////////////////////////////////////////////////

    for (genvar k = 0; k < TREE_LEVELS; k++) begin : g_level
        localparam int ROWS     = NUM_PP >> k;
        localparam int IN_BASE  = TREE_ROWS + 2 - 2 * ROWS;
        localparam int OUT_BASE = IN_BASE + ROWS;

        mul_compress_stage #(
            .ROWS (ROWS)
        ) u_stage (
            .rows_i (tree_rows[IN_BASE +: ROWS]),
            .rows_o (tree_rows[OUT_BASE +: ROWS/2])
        );
    end

    assign bus.sum_row   = tree_rows[TREE_ROWS-2];
    assign bus.carry_row = tree_rows[TREE_ROWS-1];

endmodule

// File: verification/mul_tb_model.svh
`ifndef MUL_TB_MODEL_SVH
`define MUL_TB_MODEL_SVH

// full product of the operands, each extended by its own signedness
function automatic logic [63:0] product_model(
    input logic [31:0] a,
    input logic [31:0] b,
    input logic [2:0]  f3
);
    logic        a_signed;
    logic        b_signed;
    logic [63:0] a_ext;
    logic [63:0] b_ext;

    // MULHU is unsigned on both sides, MULHSU only on b
    a_signed = (f3 != 3'd3);
    b_signed = (f3 != 3'd2) && (f3 != 3'd3);
    a_ext = {{32{a_signed & a[31]}}, a};
    b_ext = {{32{b_signed & b[31]}}, b};
    product_model = a_ext * b_ext;
endfunction

// high half for the three MULH forms, low half for everything else
function automatic logic [31:0] select_model(
    input logic [63:0] prod,
    input logic [2:0]  f3
);
    if (f3 == 3'd1 || f3 == 3'd2 || f3 == 3'd3) begin
        select_model = prod[63:32];
    end else begin
        select_model = prod[31:0];
    end
endfunction

`endif

// File: verification/mul_tb.sv
`timescale 1ns/1ps

module mul_tb;

    `include "mul_tb_model.svh"

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_RANDOM   = 500;
    localparam int NUM_CORNER   = 5 * 5 * 8;
    localparam int TIMEOUT_NS   = (NUM_RANDOM + NUM_CORNER) * 20 * CLK_PERIOD
                                  + RESET_CYCLES * CLK_PERIOD;

    logic        clk;
    logic        rst;
    logic        req;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [2:0]  func3;
    logic        ack;
    logic [31:0] result;

    integer seed = 32'h293c;
    int     value_errors = 0;
    int     protocol_errors = 0;

    logic [31:0] corners [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    mul_top u_mul_top (
        .clk_i    (clk),
        .rst_i    (rst),
        .req_i    (req),
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .func3_i  (func3),
        .ack_o    (ack),
        .result_o (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic report_protocol(input string what);
        $display("handshake problem at %0t ns: %s", $time, what);
        protocol_errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // one four-phase transaction
    ////////////////////////////////////////////////////////////

    task automatic run_op(
        input logic [31:0] a,
        input logic [31:0] b,
        input logic [2:0]  f3,
        input int          hold
    );
        logic [31:0] expected;
        int          edges;

        expected = select_model(product_model(a, b, f3), f3);
        @(negedge clk);
        op_a  = a;
        op_b  = b;
        func3 = f3;
        req   = 1'b1;
        edges = 0;
        // the sampling edge counts as the first
        while (!ack && edges < 10) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (!ack) begin
            report_protocol("ack never rose after req");
        end
        check_value(edges, 2, "ack latency in rising edges");
        check_value(result, expected, $sformatf("result a=%h b=%h f3=%0d", a, b, f3));
        // operands are free once ack is up
        op_a = $random(seed);
        op_b = $random(seed);
        repeat (hold) begin
            @(negedge clk);
            if (!ack) begin
                report_protocol("ack dropped while req was held");
            end
            check_value(result, expected, "result while req held");
        end
        req = 1'b0;
        @(negedge clk);
        if (ack) begin
            report_protocol("ack still high one edge after req fell");
        end
    endtask

    initial begin
        logic [31:0] rnd;
        int          hold;

        clk   = 1'b0;
        rst   = 1'b1;
        req   = 1'b0;
        op_a  = '0;
        op_b  = '0;
        func3 = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (ack) begin
            report_protocol("ack high right after reset");
        end
        check_value(result, 32'h0, "result after reset");

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd  = $random(seed);
            hold = {$random(seed)} % 6;
            run_op($random(seed), $random(seed), rnd[2:0], hold);
        end

        for (int f = 0; f < 8; f++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    hold = {$random(seed)} % 6;
                    run_op(corners[i], corners[j], 3'(f), hold);
                end
            end
        end

        $display("errors: %0d value, %0d handshake", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Something failed");
        $finish;
    end

endmodule

// File: list.f
+incdir+verification
source/mul_arith_pkg.sv
source/mul_op_pkg.sv
source/mul_operand_if.sv
source/mul_pp_gen.sv
source/mul_compress_stage.sv
source/mul_req_ack_ctrl.sv
source/mul_top.sv
verification/mul_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module mul_tb -o mul_tb_sim
./obj_dir/mul_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
